// ==== filelist.f ====
+incdir+include
design/csr_pkg.sv
design/lsu_pkg.sv
design/lsu_issue_queue.sv
design/vaddr_adder.sv
design/lsu_agu_ctrl.sv
design/lsu_agu_top.sv
bench/lsu_agu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the address stage testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
    -f filelist.f \
    --top-module lsu_agu_tb \
    -o lsu_agu_sim

if ! ./obj_dir/lsu_agu_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulator exited with an error, see $LOG"
    exit 1
fi
cat "$LOG"

if grep -q "Result: PASSED" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== bench/lsu_agu_tests.txt ====
# kind store rs1 imm mode type idx exp_vaddr exp_except, all hex; flush lines hold the kind only
# mode 0=BARE 8=SV39 9=SV48; type 0..6 BYTE..DOUBLEWORD; except 0=none 1=align 2=page
req 0 1000 10 0 6 0 1010 0
req 1 1000 3 0 0 1 1003 0
req 0 1000 1 0 2 2 1001 1
req 0 2000 2 0 4 3 2002 1
req 1 2000 4 0 6 4 2004 1
req 0 ffffffffffffffff 1 0 0 5 0 0
req 0 8000000000000000 0 0 6 6 8000000000000000 0
req 0 100 fffffffffffffff0 0 5 7 f0 0
req 0 3 fffffffffffffffe 0 1 0 1 0
req 0 4000000000 0 8 6 1 4000000000 2
req 0 3ffffffff8 0 8 6 2 3ffffffff8 0
req 1 ffffffc000000000 8 8 6 3 ffffffc000000008 0
req 0 ffffff8000000000 0 8 0 4 ffffff8000000000 2
req 0 4000000000 1 8 2 5 4000000001 1
req 0 7ffffffffe 0 8 3 6 7ffffffffe 2
req 0 4000000000 0 9 6 7 4000000000 0
req 0 800000000000 0 9 4 0 800000000000 2
req 1 ffff800000000000 10 9 6 1 ffff800000000010 0
req 0 7ffffffffff0 f 9 5 2 7fffffffffff 1
req 0 fffe000000000000 0 9 0 3 fffe000000000000 2
req 0 10 0 0 6 4 10 0
req 0 20 0 0 6 5 20 0
req 0 30 0 0 6 6 30 0
req 0 40 0 0 6 7 40 0
flush
req 1 5000 8 0 4 2 5008 0
req 0 5000 6 0 2 3 5006 0
req 0 ffffffbfffffffff 1 8 0 1 ffffffc000000000 0

// ==== bench/lsu_agu_tb.sv ====
// Run from the project root to find bench/lsu_agu_tests.txt; satp mode only changes while idle
`include "lsu_defines.svh"

module lsu_agu_tb;

    import csr_pkg::*;
    import lsu_pkg::*;

    localparam int TIMEOUT     = 200;
    localparam int HOLD_CYCLES = 10;

    // DUT signals
    logic           clk_i;
    logic           rst_n_i;
    logic           flush_i;
    satp_mode_t     vm_mode_i;
    logic           req_valid_i;
    logic           is_store_i;
    xlen_word_t     rs1_value_i;
    xlen_word_t     imm_value_i;
    ldst_type_t     ldst_type_i;
    lsb_idx_t       lsb_idx_i;
    logic           credit_o;
    logic           out_credit_i;
    logic           res_valid_o;
    xlen_word_t     vaddr_o;
    vadder_except_t except_o;
    logic           is_store_o;
    lsb_idx_t       lsb_idx_o;

    // Expected results, keyed by request number
    xlen_word_t exp_addr  [int];
    logic [1:0] exp_exc   [int];
    logic       exp_store [int];
    lsb_idx_t   exp_idx   [int];

    // Request and credit bookkeeping
    int sent          = 0;
    int head          = 0;
    int up_returned   = 0;
    int results_seen  = 0;
    int given_total   = 0;
    int dropped_total = 0;

    // Error counters and run state
    int     value_errors = 0;
    int     proto_errors = 0;
    int     file_errors  = 0;
    bit     timed_out    = 1'b0;
    bit     hold_credits = 1'b1;
    integer seed         = 32'h697;

    lsu_agu_top DUT (.*);

    // --------------------------------------------------
    // Clock, period 4
    // --------------------------------------------------
    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    // Upstream credits still held by the bench
    function automatic int up_avail();
        return `LSU_IQ_DEPTH - sent + up_returned;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at time %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Result monitor, samples at the falling edge
    // --------------------------------------------------
    always @(negedge clk_i) begin : monitor
        if (!rst_n_i) begin
            check_value("res_valid_o in reset", 64'(res_valid_o), 64'd0);
            check_value("credit_o in reset", 64'(credit_o), 64'd0);
        end else begin
            if (credit_o) begin
                up_returned++;
                if (up_returned > sent) begin
                    proto_errors++;
                    $display("Time %0t: %0d upstream credits returned for %0d requests",
                             $time, up_returned, sent);
                end
            end
            if (flush_i) begin
                // Everything sent so far is gone, including a result shown this cycle
                dropped_total += sent - head;
                head = sent;
            end else if (res_valid_o) begin
                results_seen++;
                if (results_seen > `LSU_OUT_CREDITS + given_total) begin
                    proto_errors++;
                    $display("Time %0t: result %0d sent without a downstream credit",
                             $time, results_seen);
                end
                if (head >= sent) begin
                    proto_errors++;
                    $display("Time %0t: result arrived with no request pending", $time);
                end else begin
                    check_value($sformatf("vaddr_o of request %0d", head),
                                vaddr_o, exp_addr[head]);
                    check_value($sformatf("except_o of request %0d", head),
                                64'(except_o), 64'(exp_exc[head]));
                    check_value($sformatf("is_store_o of request %0d", head),
                                64'(is_store_o), 64'(exp_store[head]));
                    check_value($sformatf("lsb_idx_o of request %0d", head),
                                64'(lsb_idx_o), 64'(exp_idx[head]));
                    head++;
                end
            end
        end
    end

    // --------------------------------------------------
    // Downstream consumer, one credit per accepted result
    // --------------------------------------------------
    initial begin : credit_return
        int gap;
        gap = 0;
        out_credit_i = 1'b0;
        forever begin
            @(posedge clk_i);
            if (rst_n_i && !hold_credits && (results_seen > given_total) && (gap == 0)) begin
                out_credit_i <= 1'b1;
                given_total++;
                // Random pause before the next return
                gap = $unsigned($random(seed)) % 4;
            end else begin
                out_credit_i <= 1'b0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end
    end

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------
    task automatic send_request(input logic st, input xlen_word_t rs1, input xlen_word_t imm,
                                input logic [2:0] typ, input lsb_idx_t idx,
                                input xlen_word_t e_addr, input logic [1:0] e_exc);
        int waited;
        waited = 0;
        // Out of upstream credits, queue is full
        while (up_avail() == 0 && !timed_out) begin
            @(posedge clk_i);
            req_valid_i <= 1'b0;
            waited++;
            if (hold_credits && waited == HOLD_CYCLES) begin
                $display("Time %0t: releasing downstream credits", $time);
                hold_credits <= 1'b0;
            end
            if (waited >= TIMEOUT) begin
                $display("Time %0t: no upstream credit came back", $time);
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            @(posedge clk_i);
            req_valid_i <= 1'b1;
            is_store_i  <= st;
            rs1_value_i <= rs1;
            imm_value_i <= imm;
            ldst_type_i <= ldst_type_t'(typ);
            lsb_idx_i   <= idx;
            exp_addr[sent]  = e_addr;
            exp_exc[sent]   = e_exc;
            exp_store[sent] = st;
            exp_idx[sent]   = idx;
            sent++;
        end
    endtask

    // Wait for every result and every upstream credit
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk_i);
        req_valid_i  <= 1'b0;
        hold_credits <= 1'b0;
        while ((head != sent || up_avail() != `LSU_IQ_DEPTH) && !timed_out) begin
            @(posedge clk_i);
            waited++;
            if (waited >= TIMEOUT) begin
                $display("Time %0t: drain stuck with %0d results and %0d credits missing",
                         $time, sent - head, `LSU_IQ_DEPTH - up_avail());
                timed_out = 1'b1;
            end
        end
    endtask

    // One flush cycle, then wait for the refilled credits
    task automatic flush_queue();
        int waited;
        waited = 0;
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        flush_i     <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        while (up_avail() != `LSU_IQ_DEPTH && !timed_out) begin
            @(posedge clk_i);
            waited++;
            if (waited >= TIMEOUT) begin
                $display("Time %0t: upstream credits not regained after flush", $time);
                timed_out = 1'b1;
            end
        end
        $display("Time %0t: flush dropped %0d requests in total", $time, dropped_total);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin : stimulus
        int         fd;
        int         cnt;
        string      line;
        string      kind;
        logic       st;
        xlen_word_t rs1;
        xlen_word_t imm;
        logic [3:0] mode;
        logic [3:0] cur_mode;
        logic [2:0] typ;
        lsb_idx_t   idx;
        xlen_word_t e_addr;
        logic [1:0] e_exc;

        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        vm_mode_i   = BARE;
        req_valid_i = 1'b0;
        is_store_i  = 1'b0;
        rs1_value_i = '0;
        imm_value_i = '0;
        ldst_type_i = BYTE;
        lsb_idx_i   = '0;
        cur_mode    = 4'(BARE);

        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;

        fd = $fopen("bench/lsu_agu_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/lsu_agu_tests.txt");
            file_errors++;
        end else begin
            while (!timed_out) begin
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                // Skip comments and blank lines
                if (line.len() < 3 || line.getc(0) == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                              kind, st, rs1, imm, mode, typ, idx, e_addr, e_exc);
                if (kind == "flush") begin
                    flush_queue();
                end else if (kind == "req" && cnt == 9) begin
                    // Mode is sampled at issue, so switch only with nothing in flight
                    if (mode != cur_mode) begin
                        drain();
                        vm_mode_i <= satp_mode_t'(mode);
                        cur_mode = mode;
                    end
                    send_request(st, rs1, imm, typ, idx, e_addr, e_exc);
                end else begin
                    $display("Malformed line in tests file: %s", line);
                    file_errors++;
                end
            end
            $fclose(fd);
        end

        drain();

        $display("Errors: %0d value, %0d protocol, %0d file, timeout %0d, %0d requests sent",
                 value_errors, proto_errors, file_errors, timed_out, sent);
        if (value_errors == 0 && proto_errors == 0 && file_errors == 0 && !timed_out
            && sent > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== design/lsu_agu_top.sv ====
// Upstream starts with LSU_IQ_DEPTH credits; results are pulses that the consumer cannot stall
`include "lsu_defines.svh"

module lsu_agu_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  csr_pkg::satp_mode_t     vm_mode_i,
    input  logic                    req_valid_i,
    input  logic                    is_store_i,
    input  lsu_pkg::xlen_word_t     rs1_value_i,
    input  lsu_pkg::xlen_word_t     imm_value_i,
    input  lsu_pkg::ldst_type_t     ldst_type_i,
    input  lsu_pkg::lsb_idx_t       lsb_idx_i,
    output logic                    credit_o,
    input  logic                    out_credit_i,
    output logic                    res_valid_o,
    output lsu_pkg::xlen_word_t     vaddr_o,
    output lsu_pkg::vadder_except_t except_o,
    output logic                    is_store_o,
    output lsu_pkg::lsb_idx_t       lsb_idx_o
);

    import lsu_pkg::*;

    // Queue head
    logic       head_is_store;
    xlen_word_t head_rs1_value;
    xlen_word_t head_imm_value;
    ldst_type_t head_ldst_type;
    lsb_idx_t   head_lsb_idx;

    // Control
    logic                    iq_empty;
    logic [`LSU_CNT_LEN-1:0] iq_count;
    logic                    issue;

    // --------------------------------------------------
    // Issue queue
    // --------------------------------------------------
    lsu_issue_queue u_issue_queue (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .push_i      (req_valid_i),
        .pop_i       (issue),
        .is_store_i  (is_store_i),
        .rs1_value_i (rs1_value_i),
        .imm_value_i (imm_value_i),
        .ldst_type_i (ldst_type_i),
        .lsb_idx_i   (lsb_idx_i),
        .is_store_o  (head_is_store),
        .rs1_value_o (head_rs1_value),
        .imm_value_o (head_imm_value),
        .ldst_type_o (head_ldst_type),
        .lsb_idx_o   (head_lsb_idx),
        .empty_o     (iq_empty),
        .count_o     (iq_count)
    );

    // --------------------------------------------------
    // Address adder
    // --------------------------------------------------
    vaddr_adder u_vaddr_adder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .load_i      (issue),
        .vm_mode_i   (vm_mode_i),
        .is_store_i  (head_is_store),
        .rs1_value_i (head_rs1_value),
        .imm_value_i (head_imm_value),
        .ldst_type_i (head_ldst_type),
        .lsb_idx_i   (head_lsb_idx),
        .res_valid_o (res_valid_o),
        .is_store_o  (is_store_o),
        .vaddr_o     (vaddr_o),
        .lsb_idx_o   (lsb_idx_o),
        .except_o    (except_o)
    );

    // --------------------------------------------------
    // Credit and issue control
    // --------------------------------------------------
    lsu_agu_ctrl u_agu_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .empty_i      (iq_empty),
        .count_i      (iq_count),
        .res_valid_i  (res_valid_o),
        .out_credit_i (out_credit_i),
        .issue_o      (issue),
        .credit_o     (credit_o)
    );

endmodule

// ==== design/lsu_agu_ctrl.sv ====
// Consumer must accept every result and return at most LSU_OUT_CREDITS credits in flight
`include "lsu_defines.svh"

module lsu_agu_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    empty_i,
    input  logic [`LSU_CNT_LEN-1:0] count_i,
    input  logic                    res_valid_i,
    input  logic                    out_credit_i,
    output logic                    issue_o,
    output logic                    credit_o
);

    import lsu_pkg::*;

    localparam int CNT_W = `LSU_CNT_LEN;

    agu_ctrl_state_t  state_q, state_d;
    logic [CNT_W-1:0] refill_q, refill_d;
    logic [CNT_W-1:0] out_cnt_q, out_cnt_d;
    logic             refill_active;

    assign refill_active = (state_q == REFILL);

    // --------------------------------------------------
    // Issue and upstream credit return
    // --------------------------------------------------

    // Needs a queued entry and a downstream credit
    assign issue_o = !empty_i && (out_cnt_q != '0) && !refill_active && !flush_i;

    // One credit per dequeue, or one per refill cycle
    assign credit_o = issue_o || refill_active;

    // --------------------------------------------------
    // Downstream credit counter
    // --------------------------------------------------
    always_comb begin : out_cnt_next
        out_cnt_d = out_cnt_q;
        if (out_credit_i) begin
            out_cnt_d = out_cnt_d + 1'b1;
        end
        if (issue_o) begin
            out_cnt_d = out_cnt_d - 1'b1;
        end
        // Flushed result never reaches the consumer
        if (flush_i && res_valid_i) begin
            out_cnt_d = out_cnt_d + 1'b1;
        end
    end

    // --------------------------------------------------
    // RUN/REFILL FSM
    // --------------------------------------------------
    always_comb begin : fsm_next
        state_d  = state_q;
        refill_d = refill_q;
        if (flush_i) begin
            // Flushed entries join any refill still pending
            refill_d = refill_q - CNT_W'(refill_active) + count_i;
            state_d  = (refill_d != '0) ? REFILL : RUN;
        end else if (refill_active) begin
            refill_d = refill_q - 1'b1;
            if (refill_q == CNT_W'(1)) begin
                state_d = RUN;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_regs
        if (!rst_n_i) begin
            state_q   <= RUN;
            refill_q  <= '0;
            out_cnt_q <= CNT_W'(`LSU_OUT_CREDITS);
        end else begin
            state_q   <= state_d;
            refill_q  <= refill_d;
            out_cnt_q <= out_cnt_d;
        end
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // Consumer never returns more than it was given
    a_out_cnt_max : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_cnt_q <= CNT_W'(`LSU_OUT_CREDITS))
        else $error("downstream credit overflow");

    // Flush of a non-empty queue blocks issue on the next cycle
    a_no_issue_refill : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (flush_i && (count_i != '0)) |=> !issue_o)
        else $error("issue during credit refill");

endmodule

// ==== design/vaddr_adder.sv ====
// Result fields are valid only while res_valid_o is high; canonical check assumes a 64-bit address
module vaddr_adder (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    load_i,
    input  csr_pkg::satp_mode_t     vm_mode_i,
    input  logic                    is_store_i,
    input  lsu_pkg::xlen_word_t     rs1_value_i,
    input  lsu_pkg::xlen_word_t     imm_value_i,
    input  lsu_pkg::ldst_type_t     ldst_type_i,
    input  lsu_pkg::lsb_idx_t       lsb_idx_i,
    output logic                    res_valid_o,
    output logic                    is_store_o,
    output lsu_pkg::xlen_word_t     vaddr_o,
    output lsu_pkg::lsb_idx_t       lsb_idx_o,
    output lsu_pkg::vadder_except_t except_o
);

    import csr_pkg::*;
    import lsu_pkg::*;

    // Registered request
    logic       valid_q;
    xlen_word_t rs1_value_q;
    xlen_word_t imm_value_q;
    ldst_type_t ldst_type_q;
    satp_mode_t vm_mode_q;

    // Exception flags before priority
    logic align_except;
    logic pfault_except;

    // --------------------------------------------------
    // Input register
    // --------------------------------------------------

    // Valid lasts one cycle per load, flush kills it
    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_i;
        end
    end

    // Payload, mode sampled together with the request
    always_ff @(posedge clk_i) begin : payload_reg
        if (load_i) begin
            is_store_o  <= is_store_i;
            rs1_value_q <= rs1_value_i;
            imm_value_q <= imm_value_i;
            ldst_type_q <= ldst_type_i;
            lsb_idx_o   <= lsb_idx_i;
            vm_mode_q   <= vm_mode_i;
        end
    end

    assign res_valid_o = valid_q;

    // --------------------------------------------------
    // Address sum, wraps modulo 2^64
    // --------------------------------------------------
    assign vaddr_o = rs1_value_q + imm_value_q;

    // --------------------------------------------------
    // Exception classification
    // --------------------------------------------------
    always_comb begin : except_check
        // Upper bits must replicate the top VA bit of the mode
        case (vm_mode_q)
            SV39:    pfault_except = (vaddr_o[63:39] != {25{vaddr_o[38]}});
            SV48:    pfault_except = (vaddr_o[63:48] != {16{vaddr_o[47]}});
            default: pfault_except = 1'b0;
        endcase

        // Natural alignment by access size
        case (ldst_type_q)
            HALFWORD, HALFWORD_U: align_except = vaddr_o[0];
            WORD, WORD_U:         align_except = (vaddr_o[1:0] != 2'b00);
            DOUBLEWORD:           align_except = (vaddr_o[2:0] != 3'b000);
            default:              align_except = 1'b0;
        endcase

        // Misaligned wins over page fault
        if (align_except) begin
            except_o = ALIGN_EXCEPT;
        end else if (pfault_except) begin
            except_o = PAGE_EXCEPT;
        end else begin
            except_o = NO_EXCEPT;
        end
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // Byte access without translation is always legal
    a_bare_byte_ok : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (res_valid_o && (vm_mode_q == BARE) && (ldst_type_q inside {BYTE, BYTE_U}))
        |-> (except_o == NO_EXCEPT))
        else $error("exception on bare byte access");

endmodule

// ==== design/lsu_issue_queue.sv ====
// Upstream must hold a credit per push and must not push in a flush cycle; no full flag exists
`include "lsu_defines.svh"

module lsu_issue_queue (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     push_i,
    input  logic                     pop_i,
    input  logic                     is_store_i,
    input  lsu_pkg::xlen_word_t      rs1_value_i,
    input  lsu_pkg::xlen_word_t      imm_value_i,
    input  lsu_pkg::ldst_type_t      ldst_type_i,
    input  lsu_pkg::lsb_idx_t        lsb_idx_i,
    output logic                     is_store_o,
    output lsu_pkg::xlen_word_t      rs1_value_o,
    output lsu_pkg::xlen_word_t      imm_value_o,
    output lsu_pkg::ldst_type_t      ldst_type_o,
    output lsu_pkg::lsb_idx_t        lsb_idx_o,
    output logic                     empty_o,
    output logic [`LSU_CNT_LEN-1:0]  count_o
);

    import lsu_pkg::*;

    localparam int PTR_W = $clog2(`LSU_IQ_DEPTH);
    localparam int CNT_W = `LSU_CNT_LEN;

    // Slot storage
    logic       is_store_mem  [`LSU_IQ_DEPTH];
    xlen_word_t rs1_value_mem [`LSU_IQ_DEPTH];
    xlen_word_t imm_value_mem [`LSU_IQ_DEPTH];
    ldst_type_t ldst_type_mem [`LSU_IQ_DEPTH];
    lsb_idx_t   lsb_idx_mem   [`LSU_IQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Pointer increment with wrap at the last slot
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`LSU_IQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin : ptr_regs
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Drop every pending entry
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // --------------------------------------------------
    // Slot write
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin : slot_write
        if (push_i) begin
            is_store_mem[wr_ptr_q]  <= is_store_i;
            rs1_value_mem[wr_ptr_q] <= rs1_value_i;
            imm_value_mem[wr_ptr_q] <= imm_value_i;
            ldst_type_mem[wr_ptr_q] <= ldst_type_i;
            lsb_idx_mem[wr_ptr_q]   <= lsb_idx_i;
        end
    end

    // Head of the queue, valid while not empty
    assign is_store_o  = is_store_mem[rd_ptr_q];
    assign rs1_value_o = rs1_value_mem[rd_ptr_q];
    assign imm_value_o = imm_value_mem[rd_ptr_q];
    assign ldst_type_o = ldst_type_mem[rd_ptr_q];
    assign lsb_idx_o   = lsb_idx_mem[rd_ptr_q];

    assign empty_o = (count_q == '0);
    assign count_o = count_q;

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // Upstream credits keep pushes away from a full queue
    a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> (count_q != CNT_W'(`LSU_IQ_DEPTH)))
        else $error("issue queue push while full");

    // Control only issues from a non-empty queue
    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o)
        else $error("issue queue pop while empty");

endmodule

// ==== design/lsu_pkg.sv ====
// Load/store request and result types; widths follow lsu_defines.svh, enum encodings are fixed
`include "lsu_defines.svh"

package lsu_pkg;

    // --------------------------------------------------
    // Operand and index vectors
    // --------------------------------------------------

    // Register operands, immediates and virtual addresses
    typedef logic [`LSU_XLEN-1:0] xlen_word_t;

    // Slot index in the load/store buffer
    typedef logic [`LSU_IDX_LEN-1:0] lsb_idx_t;

    // --------------------------------------------------
    // Access type
    // --------------------------------------------------

    // Size and sign extension of the memory access
    // _U variants are zero extended loads
    typedef enum logic [2:0] {
        BYTE       = 3'd0,
        BYTE_U     = 3'd1,
        HALFWORD   = 3'd2,
        HALFWORD_U = 3'd3,
        WORD       = 3'd4,
        WORD_U     = 3'd5,
        DOUBLEWORD = 3'd6
    } ldst_type_t;

    // --------------------------------------------------
    // Address exceptions
    // --------------------------------------------------

    // Misalignment has priority over the page fault
    typedef enum logic [1:0] {
        NO_EXCEPT    = 2'd0,
        ALIGN_EXCEPT = 2'd1,
        PAGE_EXCEPT  = 2'd2
    } vadder_except_t;

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------

    // RUN issues requests, REFILL returns flushed credits
    typedef enum logic {
        RUN    = 1'b0,
        REFILL = 1'b1
    } agu_ctrl_state_t;

endpackage

// ==== design/csr_pkg.sv ====
// Only the satp MODE field is described; MODE encodings other than BARE, SV39, SV48 are unsupported
package csr_pkg;

    // --------------------------------------------------
    // satp register fields
    // --------------------------------------------------

    // Width of the MODE field in satp (RV64)
    localparam int SATP_MODE_LEN = 4;

    // Translation modes as encoded in satp.MODE
    // Values 1-7 are reserved, 10 and up are other schemes
    typedef enum logic [SATP_MODE_LEN-1:0] {
        BARE = 4'd0,
        SV39 = 4'd8,
        SV48 = 4'd9
    } satp_mode_t;

endpackage

// ==== include/lsu_defines.svh ====
// Sizing macros for the address stage; LSU_CNT_LEN must hold values up to LSU_IQ_DEPTH
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------

// Data and address width of the core
`define LSU_XLEN 64

// Width of a load/store buffer index
`define LSU_IDX_LEN 3

// --------------------------------------------------
// Flow control sizing
// --------------------------------------------------

// Issue queue slots, equal to the upstream credit count
`define LSU_IQ_DEPTH 4

// Downstream credits held after reset
`define LSU_OUT_CREDITS 2

// Credit and occupancy counter width
// Wide enough for LSU_IQ_DEPTH and LSU_OUT_CREDITS
`define LSU_CNT_LEN 3

`endif
